// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_memSubsys
FILELIST  = vlog.f
PASS_MSG  = *** TEST PASSED ***

.PHONY: sim clean

# build, run, and pass only if the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: rtl/ahbLite.sv
// single-transfer AHB-Lite master
`default_nettype none
`include "mem_macros.svh"

module ahbLite (
  input  wire logic                clk,
  input  wire logic                rstN,
  input  wire logic                busStart,
  input  wire logic [`PA_BITS-1:0] busAdr,
  input  wire logic                busWrite,
  input  wire memPkg::xlenT        busWData,
  output logic                     busDone,
  output memPkg::xlenT             busRData,
  output logic [`PA_BITS-1:0]      HADDR,
  output logic                     HWRITE,
  output logic [2:0]               HSIZE,
  output memPkg::htransT           HTRANS,
  output memPkg::xlenT             HWDATA,
  input  wire memPkg::xlenT        HRDATA,
  input  wire logic                HREADY
);

  logic                addrPhaseQ;
  logic                dataPhaseQ;
  logic [`PA_BITS-1:0] adrQ;
  logic                writeQ;
  memPkg::xlenT        wDataQ;

  ////////////////////
  // phases

  // bus is idle before each transfer, so the address phase is one cycle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      addrPhaseQ <= 1'b0;
      dataPhaseQ <= 1'b0;
    end else begin
      addrPhaseQ <= busStart;
      dataPhaseQ <= addrPhaseQ || (dataPhaseQ && !HREADY);  // slave stretches it
    end
  end

  always_ff @(posedge clk) begin
    if (busStart) begin
      adrQ   <= busAdr;
      writeQ <= busWrite;
      wDataQ <= busWData;  // held into the data phase
    end
  end

  assign HTRANS = addrPhaseQ ? memPkg::NONSEQ : memPkg::IDLE;
  assign HADDR  = adrQ;
  assign HWRITE = writeQ;
  assign HSIZE  = 3'b010;   // word
  assign HWDATA = wDataQ;

  assign busDone  = dataPhaseQ && HREADY;
  assign busRData = HRDATA;

  // lsu never starts while a transfer is pending
  assert property (@(posedge clk) disable iff (!rstN)
    busStart |-> !addrPhaseQ && !dataPhaseQ);

endmodule

`default_nettype wire

// File: rtl/dtlb.sv
// data TLB
`default_nettype none
`include "mem_macros.svh"

module dtlb (
  input  wire logic                        clk,
  input  wire logic                        rstN,
  input  wire logic [`XLEN-`PAGE_BITS-1:0] vpn,
  output logic [`PA_BITS-`PAGE_BITS-1:0]   lookupPpn,
  output logic                             hit,
  output logic                             permR,
  output logic                             permW,
  input  wire logic                        tlbWrite,
  input  wire memPkg::pteT                 writePte,
  input  wire logic                        tlbFlush
);

  localparam int PtrBits = $clog2(`TLB_ENTRIES);

  logic [`TLB_ENTRIES-1:0]        validQ;
  logic [`XLEN-`PAGE_BITS-1:0]    tagQ [`TLB_ENTRIES];
  logic [`PA_BITS-`PAGE_BITS-1:0] ppnQ [`TLB_ENTRIES];
  logic [`TLB_ENTRIES-1:0]        readQ;
  logic [`TLB_ENTRIES-1:0]        writeQ;
  logic [PtrBits-1:0]             fillPtrQ;  // round-robin victim
  logic [`TLB_ENTRIES-1:0]        match;

  ////////////////////
  // lookup

  always_comb begin
    lookupPpn = '0;
    permR     = 1'b0;
    permW     = 1'b0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      match[i] = validQ[i] && (tagQ[i] == vpn);  // all tags in parallel
      if (match[i]) begin
        lookupPpn = ppnQ[i];
        permR     = readQ[i];
        permW     = writeQ[i];
      end
    end
  end

  assign hit = |match;

  ////////////////////
  // fill and flush

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validQ   <= '0;
      fillPtrQ <= '0;
    end else if (tlbFlush) begin
      validQ <= '0;  // pointer keeps going
    end else if (tlbWrite) begin
      validQ[fillPtrQ] <= 1'b1;
      fillPtrQ         <= fillPtrQ + PtrBits'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (tlbWrite) begin
      tagQ[fillPtrQ]   <= vpn;
      ppnQ[fillPtrQ]   <= writePte[`PTE_PPN_HI:`PTE_PPN_LO];
      readQ[fillPtrQ]  <= writePte[`PTE_R];
      writeQ[fillPtrQ] <= writePte[`PTE_W];
    end
  end

  // walker only fills after a miss, so a tag never lands twice
  assert property (@(posedge clk) disable iff (!rstN) $onehot0(match));

endmodule

`default_nettype wire

// File: rtl/lsu.sv
// load/store unit
`default_nettype none
`include "mem_macros.svh"

module lsu (
  input  wire logic                clk,
  input  wire logic                rstN,
  input  wire logic                lsuReq,
  input  wire logic                lsuWrite,
  input  wire memPkg::xlenT        lsuAdr,
  input  wire memPkg::xlenT        lsuWData,
  input  wire logic                disableTranslation,
  input  wire memPkg::xlenT        satp,
  input  wire logic                tlbFlush,
  output logic                     dtlbMiss,
  input  wire logic                dtlbWrite,
  input  wire memPkg::pteT         writePte,
  output logic                     lsuAck,
  output memPkg::xlenT             lsuRData,
  output logic                     loadPageFault,
  output logic                     storePageFault,
  output logic [`PA_BITS-1:0]      HADDR,
  output logic                     HWRITE,
  output logic [2:0]               HSIZE,
  output memPkg::htransT           HTRANS,
  output memPkg::xlenT             HWDATA,
  input  wire memPkg::xlenT        HRDATA,
  input  wire logic                HREADY
);

  logic                           translate;
  logic                           idle;
  logic                           permOk;
  logic                           permFault;
  logic                           busyQ;        // bus transfer in flight
  logic                           loadFaultQ;
  logic                           storeFaultQ;
  logic                           tlbHit;
  logic                           permR;
  logic                           permW;
  logic [`XLEN-`PAGE_BITS-1:0]    vpn;
  logic [`XLEN-`PAGE_BITS-1:0]    missVpnQ;     // tag for the coming fill
  logic [`PA_BITS-`PAGE_BITS-1:0] ppn;
  logic                           busStart;
  logic                           busDone;
  logic [`PA_BITS-1:0]            busAdr;
  memPkg::xlenT                   busRData;

  assign translate = satp[`XLEN-1] && !disableTranslation;
  assign idle      = !busyQ && !loadFaultQ && !storeFaultQ;  // one request at a time

  // during a walk the lookup port carries the missed page
  assign vpn = disableTranslation ? missVpnQ : lsuAdr[`XLEN-1:`PAGE_BITS];

  assign permOk    = lsuWrite ? permW : permR;
  assign dtlbMiss  = lsuReq && idle && translate && !tlbHit;
  assign permFault = lsuReq && idle && translate && tlbHit && !permOk;
  assign busStart  = lsuReq && idle && (!translate || (tlbHit && permOk));
  assign busAdr    = translate ? {ppn, lsuAdr[`PAGE_BITS-1:0]} : lsuAdr[`PA_BITS-1:0];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      busyQ       <= 1'b0;
      loadFaultQ  <= 1'b0;
      storeFaultQ <= 1'b0;
    end else begin
      if (busStart) begin
        busyQ <= 1'b1;
      end else if (busDone) begin
        busyQ <= 1'b0;
      end
      loadFaultQ  <= permFault && !lsuWrite;  // completes next cycle
      storeFaultQ <= permFault && lsuWrite;
    end
  end

  always_ff @(posedge clk) begin
    if (dtlbMiss) begin
      missVpnQ <= lsuAdr[`XLEN-1:`PAGE_BITS];
    end
  end

  assign lsuAck         = busDone || loadFaultQ || storeFaultQ;
  assign lsuRData       = busRData;
  assign loadPageFault  = loadFaultQ;
  assign storePageFault = storeFaultQ;

  dtlb dtlb (
    .clk(clk), .rstN(rstN),
    .vpn(vpn), .lookupPpn(ppn), .hit(tlbHit), .permR(permR), .permW(permW),
    .tlbWrite(dtlbWrite), .writePte(writePte), .tlbFlush(tlbFlush)
  );

  ahbLite ebu (
    .clk(clk), .rstN(rstN),
    .busStart(busStart), .busAdr(busAdr), .busWrite(lsuWrite), .busWData(lsuWData),
    .busDone(busDone), .busRData(busRData),
    .HADDR(HADDR), .HWRITE(HWRITE), .HSIZE(HSIZE), .HTRANS(HTRANS),
    .HWDATA(HWDATA), .HRDATA(HRDATA), .HREADY(HREADY)
  );

  assert property (@(posedge clk) disable iff (!rstN) !(busStart && translate && !tlbHit));

  // walker takes the port right after a miss
  assert property (@(posedge clk) disable iff (!rstN) dtlbMiss |=> disableTranslation);

endmodule

`default_nettype wire

// File: rtl/lsuArb.sv
// core and walker arbiter for the lsu port
`default_nettype none

module lsuArb (
  // core
  input  wire logic         memReq,
  input  wire logic         memWrite,
  input  wire memPkg::xlenT memAdr,
  input  wire memPkg::xlenT memWData,
  output logic              memDone,
  output memPkg::xlenT      memRData,
  output logic              loadPageFault,
  output logic              storePageFault,
  // walker
  input  wire logic         walkActive,
  input  wire logic         hptwRead,
  input  wire memPkg::xlenT hptwPAdr,
  output logic              hptwReady,
  output memPkg::pteT       hptwReadPte,
  input  wire logic         walkLoadPageFault,
  input  wire logic         walkStorePageFault,
  // lsu
  output logic              lsuReq,
  output logic              lsuWrite,
  output memPkg::xlenT      lsuAdr,
  output memPkg::xlenT      lsuWData,
  output logic              disableTranslation,
  input  wire logic         lsuAck,
  input  wire memPkg::xlenT lsuRData,
  input  wire logic         lsuLoadPageFault,
  input  wire logic         lsuStorePageFault
);

  // walker owns the port for the whole walk
  assign lsuReq             = walkActive ? hptwRead : memReq;
  assign lsuWrite           = walkActive ? 1'b0 : memWrite;  // pte reads only
  assign lsuAdr             = walkActive ? hptwPAdr : memAdr;
  assign lsuWData           = memWData;
  assign disableTranslation = walkActive;  // pte address is physical

  // ack back to whoever owns the port
  assign hptwReady   = walkActive && lsuAck;
  assign hptwReadPte = lsuRData;
  assign memRData    = lsuRData;

  // walker faults end the core request as well
  assign memDone        = (!walkActive && lsuAck) || walkLoadPageFault || walkStorePageFault;
  assign loadPageFault  = lsuLoadPageFault || walkLoadPageFault;
  assign storePageFault = lsuStorePageFault || walkStorePageFault;

endmodule

`default_nettype wire

// File: rtl/memPkg.sv
// memory subsystem types
`default_nettype none
`include "mem_macros.svh"

package memPkg;

  typedef logic [`XLEN-1:0] xlenT;  // data and addresses
  typedef logic [31:0]      pteT;   // one page table entry

  // ahb-lite transfer type
  // single transfers only, so no BUSY or SEQ
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    NONSEQ = 2'b10
  } htransT;

  // page table walker
  typedef enum logic [1:0] {
    WALK_IDLE,
    WALK_READ,  // pte read handed to the lsu
    WALK_WAIT,  // pte read on the bus
    WALK_FILL   // write tlb or raise fault
  } walkStateT;

endpackage

`default_nettype wire

// File: rtl/memSubsys.sv
// data memory subsystem top
`default_nettype none
`include "mem_macros.svh"

module memSubsys (
  input  wire logic                clk,
  input  wire logic                rstN,
  // core memory stage
  input  wire logic                memReq,
  input  wire logic                memWrite,
  input  wire memPkg::xlenT        memAdr,
  input  wire memPkg::xlenT        memWData,
  input  wire memPkg::xlenT        satp,
  input  wire logic                tlbFlush,
  output memPkg::xlenT             memRData,
  output logic                     memDone,
  output logic                     loadPageFault,
  output logic                     storePageFault,
  // ahb-lite
  output logic [`PA_BITS-1:0]      HADDR,
  output logic                     HWRITE,
  output logic [2:0]               HSIZE,
  output memPkg::htransT           HTRANS,
  output memPkg::xlenT             HWDATA,
  input  wire memPkg::xlenT        HRDATA,
  input  wire logic                HREADY
);

  // arbiter to lsu
  logic         lsuReq, lsuWrite, disableTranslation;
  memPkg::xlenT lsuAdr, lsuWData, lsuRData;
  logic         lsuAck, lsuLoadPageFault, lsuStorePageFault;
  // walker
  logic         walkActive, hptwRead, hptwReady;
  memPkg::xlenT hptwPAdr;
  memPkg::pteT  hptwReadPte, writePte;
  logic         dtlbMiss, dtlbWrite, walkLoadPageFault, walkStorePageFault;

  pageTableWalker hptw (
    .clk(clk), .rstN(rstN),
    .dtlbMiss(dtlbMiss), .satp(satp), .memAdr(memAdr), .memWrite(memWrite),
    .walkActive(walkActive), .hptwRead(hptwRead), .hptwPAdr(hptwPAdr),
    .hptwReady(hptwReady), .hptwReadPte(hptwReadPte),
    .dtlbWrite(dtlbWrite), .writePte(writePte),
    .loadPageFault(walkLoadPageFault), .storePageFault(walkStorePageFault)
  );

  lsuArb arbiter (
    .memReq(memReq), .memWrite(memWrite), .memAdr(memAdr), .memWData(memWData),
    .memDone(memDone), .memRData(memRData),
    .loadPageFault(loadPageFault), .storePageFault(storePageFault),
    .walkActive(walkActive), .hptwRead(hptwRead), .hptwPAdr(hptwPAdr),
    .hptwReady(hptwReady), .hptwReadPte(hptwReadPte),
    .walkLoadPageFault(walkLoadPageFault), .walkStorePageFault(walkStorePageFault),
    .lsuReq(lsuReq), .lsuWrite(lsuWrite), .lsuAdr(lsuAdr), .lsuWData(lsuWData),
    .disableTranslation(disableTranslation), .lsuAck(lsuAck), .lsuRData(lsuRData),
    .lsuLoadPageFault(lsuLoadPageFault), .lsuStorePageFault(lsuStorePageFault)
  );

  lsu lsu (
    .clk(clk), .rstN(rstN),
    .lsuReq(lsuReq), .lsuWrite(lsuWrite), .lsuAdr(lsuAdr), .lsuWData(lsuWData),
    .disableTranslation(disableTranslation), .satp(satp), .tlbFlush(tlbFlush),
    .dtlbMiss(dtlbMiss), .dtlbWrite(dtlbWrite), .writePte(writePte),
    .lsuAck(lsuAck), .lsuRData(lsuRData),
    .loadPageFault(lsuLoadPageFault), .storePageFault(lsuStorePageFault),
    .HADDR(HADDR), .HWRITE(HWRITE), .HSIZE(HSIZE), .HTRANS(HTRANS),
    .HWDATA(HWDATA), .HRDATA(HRDATA), .HREADY(HREADY)
  );

endmodule

`default_nettype wire

// File: rtl/mem_macros.svh
// memory subsystem parameters
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

////////////////////
// widths

`define XLEN        32   // data and virtual address
`define PA_BITS     32   // physical address
`define PAGE_BITS   12   // 4 KiB pages

////////////////////
// translation

`define TLB_ENTRIES 4    // power of two, fill pointer wraps

// pte layout, single level table
`define PTE_V       0
`define PTE_R       1
`define PTE_W       2
`define PTE_PPN_LO  10
`define PTE_PPN_HI  29

`endif

// File: rtl/pageTableWalker.sv
// one-level page table walker
`default_nettype none
`include "mem_macros.svh"

module pageTableWalker (
  input  wire logic         clk,
  input  wire logic         rstN,
  input  wire logic         dtlbMiss,
  input  wire memPkg::xlenT satp,
  input  wire memPkg::xlenT memAdr,
  input  wire logic         memWrite,
  output logic              walkActive,
  output logic              hptwRead,
  output memPkg::xlenT      hptwPAdr,
  input  wire logic         hptwReady,
  input  wire memPkg::pteT  hptwReadPte,
  output logic              dtlbWrite,
  output memPkg::pteT       writePte,
  output logic              loadPageFault,
  output logic              storePageFault
);

  memPkg::walkStateT stateQ;
  memPkg::walkStateT stateNext;
  memPkg::pteT       pteQ;
  logic              pteFault;

  // root ppn << 12 plus 4 bytes per vpn index
  // root bits above the physical range drop out
  assign hptwPAdr = {satp[`PA_BITS-`PAGE_BITS-1:0], {`PAGE_BITS{1'b0}}}
                  + {{(`PA_BITS-`PAGE_BITS){1'b0}}, memAdr[21:`PAGE_BITS], 2'b00};

  ////////////////////
  // fsm

  always_comb begin
    stateNext = stateQ;
    case (stateQ)
      memPkg::WALK_IDLE: if (dtlbMiss) stateNext = memPkg::WALK_READ;
      memPkg::WALK_READ: stateNext = memPkg::WALK_WAIT;  // lsu started the read
      memPkg::WALK_WAIT: if (hptwReady) stateNext = memPkg::WALK_FILL;
      default:           stateNext = memPkg::WALK_IDLE;  // fill is one cycle
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      stateQ <= memPkg::WALK_IDLE;
    end else begin
      stateQ <= stateNext;
    end
  end

  always_ff @(posedge clk) begin
    if (stateQ == memPkg::WALK_WAIT && hptwReady) begin
      pteQ <= hptwReadPte;  // pte word from the bus
    end
  end

  // fill stays active so the lsu sits out the fault cycle too
  assign walkActive = stateQ != memPkg::WALK_IDLE;
  assign hptwRead   = stateQ == memPkg::WALK_READ || stateQ == memPkg::WALK_WAIT;

  assign pteFault       = stateQ == memPkg::WALK_FILL && !pteQ[`PTE_V];
  assign dtlbWrite      = stateQ == memPkg::WALK_FILL && pteQ[`PTE_V];
  assign writePte       = pteQ;
  assign loadPageFault  = pteFault && !memWrite;  // core holds memWrite
  assign storePageFault = pteFault && memWrite;

  assert property (@(posedge clk) disable iff (!rstN)
    !(dtlbWrite && (loadPageFault || storePageFault)));

  // retried lookup after a fill must hit
  assert property (@(posedge clk) disable iff (!rstN) dtlbWrite |=> !dtlbMiss);

endmodule

`default_nettype wire

// File: sim/mem_tests.txt
# op addr data fault count (hex). fault 0 none, 1 load page fault, 2 store page fault
# P addr data preloads memory before the run, M value sets satp, F flushes the TLB
P 00003014 00000407
P 00003018 00000000
P 0000301C 00000803
P 00003020 00000405
P 00001010 11112222
P 00002020 33334444
# bare mode
S 00000100 CAFEF00D 0 1
L 00000100 CAFEF00D 0 1
# translate, root table at ppn 3
M 80000003
L 00005010 11112222 0 2
L 00005010 11112222 0 1
S 00005024 A5A5A5A5 0 1
L 00005024 A5A5A5A5 0 1
# page 6 has an invalid pte
L 00006000 00000000 1 1
S 00006004 DEADBEEF 2 1
# page 7 read only, page 8 write only
L 00007020 33334444 0 2
S 00007020 55555555 2 0
L 00007020 33334444 0 1
L 00008000 00000000 1 1
S 00008008 77778888 0 1
F
L 00005010 11112222 0 2
L 00005024 A5A5A5A5 0 1
# back to bare mode to look at physical memory
M 00000000
L 00001008 77778888 0 1
L 00001024 A5A5A5A5 0 1
L 00002020 33334444 0 1

// File: sim/tb_memSubsys.sv
// memory subsystem testbench
`default_nettype none
`include "mem_macros.svh"

module tb_memSubsys;
  timeunit 1ns;
  timeprecision 100ps;

  logic                clk;
  logic                rstN;
  logic                memReq;
  logic                memWrite;
  memPkg::xlenT        memAdr;
  memPkg::xlenT        memWData;
  memPkg::xlenT        satp;
  logic                tlbFlush;
  memPkg::xlenT        memRData;
  logic                memDone;
  logic                loadPageFault;
  logic                storePageFault;
  logic [`PA_BITS-1:0] HADDR;
  logic                HWRITE;
  logic [2:0]          HSIZE;
  memPkg::htransT      HTRANS;
  memPkg::xlenT        HWDATA;
  memPkg::xlenT        HRDATA;
  logic                HREADY;

  memPkg::xlenT mem [4096];       // word array on addr[13:2]
  logic [31:0]  rngState = 32'd46;
  int           nonseqCount = 0;  // address phases seen so far
  int           curLine = 0;      // test file line being run
  logic         testsLoaded = 1'b0;

  // parsed test lines
  byte         opQ [$];
  logic [31:0] f1Q [$];
  logic [31:0] f2Q [$];
  logic [31:0] f3Q [$];
  logic [31:0] f4Q [$];
  int          lineQ [$];

  memSubsys i_dut (
    .clk(clk), .rstN(rstN),
    .memReq(memReq), .memWrite(memWrite), .memAdr(memAdr), .memWData(memWData),
    .satp(satp), .tlbFlush(tlbFlush), .memRData(memRData), .memDone(memDone),
    .loadPageFault(loadPageFault), .storePageFault(storePageFault),
    .HADDR(HADDR), .HWRITE(HWRITE), .HSIZE(HSIZE), .HTRANS(HTRANS),
    .HWDATA(HWDATA), .HRDATA(HRDATA), .HREADY(HREADY)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic waitDriveSlot();
    @(posedge clk);
    #1;  // inputs move just after the edge
  endtask

  task automatic checkValue(input string what, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t ns: line %0d, %s is %h, expected %h",
               $time, curLine, what, got, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  ////////////////////
  // core side

  task automatic runAccess(input logic write, input logic [31:0] adr,
                           input logic [31:0] data, input logic [31:0] fault,
                           input logic [31:0] count);
    int           startCount;
    memPkg::xlenT rData;
    logic [1:0]   faults;
    startCount = nonseqCount;
    waitDriveSlot();
    memReq   = 1'b1;
    memWrite = write;
    memAdr   = adr;
    memWData = data;
    @(negedge clk);
    while (!memDone) begin
      @(negedge clk);  // stable mid-cycle, watchdog bounds it
    end
    rData  = memRData;
    faults = {storePageFault, loadPageFault};
    waitDriveSlot();
    memReq   = 1'b0;
    memWrite = 1'b0;
    checkValue("fault", {30'b0, faults}, fault);
    if (!write && fault == 0) begin
      checkValue("load data", rData, data);  // data only counts without fault
    end
    checkValue("transfers", nonseqCount - startCount, count);
  endtask

  task automatic pulseFlush();
    waitDriveSlot();
    tlbFlush = 1'b1;
    waitDriveSlot();
    tlbFlush = 1'b0;
  endtask

  ////////////////////
  // ahb slave

  initial begin
    logic [`PA_BITS-1:0] adr;
    logic                wr;
    logic [1:0]          waits;
    HREADY = 1'b1;
    HRDATA = '0;
    for (int i = 0; i < 4096; i++) begin
      mem[i] = {20'h0badd, i[11:0]};  // whole address in the fill
    end
    wait (testsLoaded);
    foreach (opQ[i]) begin
      if (opQ[i] == "P") begin
        mem[f1Q[i][13:2]] = f2Q[i];
      end
    end
    forever begin
      @(negedge clk);
      if (HTRANS == memPkg::NONSEQ) begin
        adr = HADDR;  // address phase
        wr  = HWRITE;
        checkValue("HSIZE", {29'b0, HSIZE}, 32'd2);  // word transfers only
        rngState = xorshift32(rngState);
        waits = rngState[1:0];  // 0 to 3 wait states
        nonseqCount++;
        waitDriveSlot();
        repeat (waits) begin
          HREADY = 1'b0;
          waitDriveSlot();
        end
        HREADY = 1'b1;  // last data phase cycle
        if (!wr) begin
          HRDATA = mem[adr[13:2]];
        end
        @(negedge clk);
        if (wr) begin
          mem[adr[13:2]] = HWDATA;
        end
      end
    end
  end

  initial begin
    wait (testsLoaded);
    repeat (300 * opQ.size() + 20) @(posedge clk);
    $display("ERROR: watchdog timeout, tests did not finish in time");
    $display("*** TEST FAILED ***");
    $fatal(1, "timeout");
  end

  ////////////////////
  // test reader and sequencer

  initial begin
    int          fd;
    int          n;
    int          lineNo;
    string       line;
    byte         op;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    rstN     = 1'b0;
    memReq   = 1'b0;
    memWrite = 1'b0;
    memAdr   = '0;
    memWData = '0;
    satp     = '0;  // bare mode
    tlbFlush = 1'b0;
    lineNo   = 0;
    fd = $fopen("sim/mem_tests.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open sim/mem_tests.txt");
      $display("*** TEST FAILED ***");
      $fatal(1, "no test file");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      lineNo++;
      if (n == 0 || line.len() < 1) continue;
      op = line[0];
      if (op == "#" || op == "\n" || op == " ") continue;  // comment or blank
      f1 = '0;
      f2 = '0;
      f3 = '0;
      f4 = '0;
      n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f1, f2, f3, f4);
      opQ.push_back(op);
      f1Q.push_back(f1);
      f2Q.push_back(f2);
      f3Q.push_back(f3);
      f4Q.push_back(f4);
      lineQ.push_back(lineNo);
    end
    $fclose(fd);
    testsLoaded = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rstN = 1'b1;
    foreach (opQ[i]) begin
      curLine = lineQ[i];
      case (opQ[i])
        "P": ;  // done by the slave before reset ends
        "M": begin
          waitDriveSlot();
          satp = f1Q[i];
        end
        "F": pulseFlush();
        "L": runAccess(1'b0, f1Q[i], f2Q[i], f3Q[i], f4Q[i]);
        "S": runAccess(1'b1, f1Q[i], f2Q[i], f3Q[i], f4Q[i]);
        default: begin
          $display("ERROR: unknown operation on line %0d of the test file", curLine);
          $display("*** TEST FAILED ***");
          $fatal(1, "bad test file");
        end
      endcase
    end
    repeat (4) @(posedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/memPkg.sv
rtl/dtlb.sv
rtl/pageTableWalker.sv
rtl/lsuArb.sv
rtl/ahbLite.sv
rtl/lsu.sv
rtl/memSubsys.sv
sim/tb_memSubsys.sv
